// File: verilog/alu_imm_cfg.svh
// ----------------------------
// alu_imm sizes
// queue depth, register and ROB counts, data width
// ----------------------------

`ifndef ALU_IMM_CFG_SVH
`define ALU_IMM_CFG_SVH

// issue queue depth
`define ALU_IMM_IQ_ENTRIES 4

// physical register file
`define PR_COUNT 64
`define LOG_PR_COUNT 6

// reorder buffer
`define ROB_ENTRIES 32
`define LOG_ROB_ENTRIES 5

`define XLEN 32

`endif

// File: verilog/alu_imm_pkg.sv
// ----------------------------
// alu_imm types
// op codes and the two views of the 12-bit immediate
// ----------------------------

`default_nettype none

package alu_imm_pkg;

	// funct3-style op select for the immediate pipe
	typedef enum logic [3:0] {
		ADDI  = 4'd0,
		SLTI  = 4'd1,
		SLTIU = 4'd2,
		XORI  = 4'd3,
		ORI   = 4'd4,
		ANDI  = 4'd5,
		SLLI  = 4'd6,
		SRLI  = 4'd7,
		SRAI  = 4'd8
	} alu_imm_op_t;

	// same 12 bits, read as a signed imm or as funct7 + shamt
	typedef union packed {
		logic signed [11:0] plain;
		struct packed {
			logic [6:0] upper;
			logic [4:0] shamt;
		} shift;
	} imm12_t;

	// funct7 value selecting arithmetic right shift
	localparam logic [6:0] SRA_UPPER = 7'b0100000;

endpackage

`default_nettype wire

// File: verilog/alu_imm_if.sv
// ----------------------------
// alu_imm op channel
// one renamed op with valid/ready between stages
// ----------------------------

`default_nettype none

`include "alu_imm_cfg.svh"

interface alu_imm_if import alu_imm_pkg::*; ();

	logic valid;
	logic ready;
	alu_imm_op_t op;
	imm12_t imm12;
	logic [`LOG_PR_COUNT-1:0] A_PR;
	// operand A already written in the register file
	logic A_ready;
	logic [`LOG_PR_COUNT-1:0] dest_PR;
	logic [`LOG_ROB_ENTRIES-1:0] ROB_index;

	modport src (
		output valid, op, imm12, A_PR, A_ready, dest_PR, ROB_index,
		input ready
	);

	modport dst (
		input valid, op, imm12, A_PR, A_ready, dest_PR, ROB_index,
		output ready
	);

endinterface

`default_nettype wire

// File: verilog/alu_imm_dispatch.sv
// ----------------------------
// alu_imm dispatch
// tracks register readiness, registers one op for the queue
// ----------------------------

`default_nettype none

`include "alu_imm_cfg.svh"

module alu_imm_dispatch import alu_imm_pkg::*; (
	input wire logic CLK,
	input wire logic nRST,
	input wire logic enq_valid,
	input wire alu_imm_op_t enq_op,
	input wire imm12_t enq_imm12,
	input wire logic [`LOG_PR_COUNT-1:0] enq_A_PR,
	input wire logic [`LOG_PR_COUNT-1:0] enq_dest_PR,
	input wire logic [`LOG_ROB_ENTRIES-1:0] enq_ROB_index,
	output logic enq_ready,
	input wire logic wb_valid,
	input wire logic [`LOG_PR_COUNT-1:0] wb_PR,
	alu_imm_if.src iq
);

	logic run;
	logic [`PR_COUNT-1:0] pr_ready;
	logic enq_fire;
	logic a_ready_now;

	// register empty or handing its op to the queue this cycle
	assign enq_ready = run && (!iq.valid || iq.ready);
	assign enq_fire = enq_valid && enq_ready;
	// table lookup plus a broadcast landing this very cycle
	assign a_ready_now = pr_ready[enq_A_PR] || (wb_valid && wb_PR == enq_A_PR);

	// held low through reset, opens on the first clock after
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST)
			run <= 1'b0;
		else
			run <= 1'b1;
	end

	// ------------------------------
	// ready table
	// ------------------------------
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			pr_ready <= `PR_COUNT'(1);
		end else begin
			if (wb_valid)
				pr_ready[wb_PR] <= 1'b1;
			// new producer claims its dest; x0 never waits
			if (enq_fire && enq_dest_PR != '0)
				pr_ready[enq_dest_PR] <= 1'b0;
		end
	end

	// ------------------------------
	// enqueue register
	// ------------------------------
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			iq.valid <= 1'b0;
			iq.A_ready <= 1'b0;
		end else if (enq_fire) begin
			iq.valid <= 1'b1;
			iq.A_ready <= a_ready_now;
		end else begin
			if (iq.ready)
				iq.valid <= 1'b0;
			// keep snooping while stalled
			if (wb_valid && wb_PR == iq.A_PR)
				iq.A_ready <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (enq_fire) begin
			iq.op <= enq_op;
			iq.imm12 <= enq_imm12;
			iq.A_PR <= enq_A_PR;
			iq.dest_PR <= enq_dest_PR;
			iq.ROB_index <= enq_ROB_index;
		end
	end

	// a refused op is held steady upstream until it is taken
	a_enq_hold: assert property (@(posedge CLK) disable iff (!nRST)
		enq_valid && !enq_ready |=> enq_valid && $stable(enq_op)
			&& $stable(enq_imm12) && $stable(enq_A_PR)
			&& $stable(enq_dest_PR) && $stable(enq_ROB_index));

endmodule

`default_nettype wire

// File: verilog/alu_imm_iq.sv
// ----------------------------
// alu_imm issue queue
// age-ordered entries, bus wakeup, oldest-ready issue
// ----------------------------

`default_nettype none

`include "alu_imm_cfg.svh"

module alu_imm_iq import alu_imm_pkg::*; (
	input wire logic CLK,
	input wire logic nRST,
	alu_imm_if.dst enq,
	alu_imm_if.src issue,
	input wire logic wb_valid,
	input wire logic [`LOG_PR_COUNT-1:0] wb_PR
);

	localparam int N = `ALU_IMM_IQ_ENTRIES;
	localparam int IDX_W = $clog2(N);

	// entry 0 is the oldest
	logic [N-1:0] ent_valid;
	logic [N-1:0] ent_ready;
	alu_imm_op_t ent_op [N];
	imm12_t ent_imm12 [N];
	logic [`LOG_PR_COUNT-1:0] ent_A_PR [N];
	logic [`LOG_PR_COUNT-1:0] ent_dest_PR [N];
	logic [`LOG_ROB_ENTRIES-1:0] ent_ROB_index [N];

	logic [N-1:0] nxt_valid;
	logic [N-1:0] nxt_ready;
	alu_imm_op_t nxt_op [N];
	imm12_t nxt_imm12 [N];
	logic [`LOG_PR_COUNT-1:0] nxt_A_PR [N];
	logic [`LOG_PR_COUNT-1:0] nxt_dest_PR [N];
	logic [`LOG_ROB_ENTRIES-1:0] nxt_ROB_index [N];

	logic [N-1:0] wake;
	logic [IDX_W-1:0] sel;
	logic [IDX_W:0] tail;
	logic [IDX_W:0] wr_idx;
	logic found;
	logic issue_fire;
	logic enq_fire;
	logic enq_wake;

	// ------------------------------
	// wakeup and select
	// ------------------------------
	always_comb begin
		found = 1'b0;
		sel = '0;
		tail = '0;
		// walk down so the lowest ready index wins
		for (int i = N - 1; i >= 0; i--) begin
			wake[i] = ent_ready[i] || (wb_valid && wb_PR == ent_A_PR[i]);
			if (ent_valid[i] && ent_ready[i]) begin
				found = 1'b1;
				sel = IDX_W'(i);
			end
			tail = tail + (IDX_W + 1)'(ent_valid[i]);
		end
	end

	assign issue.valid = found;
	assign issue.op = ent_op[sel];
	assign issue.imm12 = ent_imm12[sel];
	assign issue.A_PR = ent_A_PR[sel];
	assign issue.A_ready = ent_ready[sel];
	assign issue.dest_PR = ent_dest_PR[sel];
	assign issue.ROB_index = ent_ROB_index[sel];

	// entries stay packed, so full means the top slot is taken
	assign enq.ready = !ent_valid[N-1];
	assign issue_fire = issue.valid && issue.ready;
	assign enq_fire = enq.valid && enq.ready;
	assign wr_idx = issue_fire ? tail - 1'b1 : tail;
	assign enq_wake = enq.A_ready || (wb_valid && wb_PR == enq.A_PR);

	// ------------------------------
	// compaction and insert
	// ------------------------------
	always_comb begin
		int src;
		for (int i = 0; i < N; i++) begin
			src = i;
			// everything above the issued slot slides down one
			if (issue_fire && i >= int'(sel))
				src = i + 1;
			if (src < N) begin
				nxt_valid[i] = ent_valid[src];
				nxt_ready[i] = wake[src];
				nxt_op[i] = ent_op[src];
				nxt_imm12[i] = ent_imm12[src];
				nxt_A_PR[i] = ent_A_PR[src];
				nxt_dest_PR[i] = ent_dest_PR[src];
				nxt_ROB_index[i] = ent_ROB_index[src];
			end else begin
				nxt_valid[i] = 1'b0;
				nxt_ready[i] = 1'b0;
				nxt_op[i] = ent_op[i];
				nxt_imm12[i] = ent_imm12[i];
				nxt_A_PR[i] = ent_A_PR[i];
				nxt_dest_PR[i] = ent_dest_PR[i];
				nxt_ROB_index[i] = ent_ROB_index[i];
			end
			if (enq_fire && i == int'(wr_idx)) begin
				nxt_valid[i] = 1'b1;
				nxt_ready[i] = enq_wake;
				nxt_op[i] = enq.op;
				nxt_imm12[i] = enq.imm12;
				nxt_A_PR[i] = enq.A_PR;
				nxt_dest_PR[i] = enq.dest_PR;
				nxt_ROB_index[i] = enq.ROB_index;
			end
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			ent_valid <= '0;
			ent_ready <= '0;
		end else begin
			ent_valid <= nxt_valid;
			ent_ready <= nxt_ready;
		end
	end

	always_ff @(posedge CLK) begin
		ent_op <= nxt_op;
		ent_imm12 <= nxt_imm12;
		ent_A_PR <= nxt_A_PR;
		ent_dest_PR <= nxt_dest_PR;
		ent_ROB_index <= nxt_ROB_index;
	end

	// valid entries form one run from slot 0 with no holes
	a_packed: assert property (@(posedge CLK) disable iff (!nRST)
		(ent_valid & (ent_valid + 1'b1)) == '0);

endmodule

`default_nettype wire

// File: verilog/alu_imm_pipe.sv
// ----------------------------
// alu_imm pipe
// register read, immediate ALU, result and writeback
// ----------------------------

`default_nettype none

`include "alu_imm_cfg.svh"

module alu_imm_pipe import alu_imm_pkg::*; (
	input wire logic CLK,
	input wire logic nRST,
	alu_imm_if.dst issue,
	input wire logic ext_wb_valid,
	input wire logic [`LOG_PR_COUNT-1:0] ext_wb_PR,
	input wire logic [`XLEN-1:0] ext_wb_data,
	input wire logic res_ready,
	output logic res_valid,
	output logic [`LOG_PR_COUNT-1:0] res_dest_PR,
	output logic [`LOG_ROB_ENTRIES-1:0] res_ROB_index,
	output logic [`XLEN-1:0] res_data,
	output logic wb_valid,
	output logic [`LOG_PR_COUNT-1:0] wb_PR
);

	logic [`XLEN-1:0] rf [`PR_COUNT];

	logic s1_valid;
	alu_imm_op_t s1_op;
	imm12_t s1_imm12;
	logic [`LOG_PR_COUNT-1:0] s1_dest_PR;
	logic [`LOG_ROB_ENTRIES-1:0] s1_ROB_index;
	logic [`XLEN-1:0] s1_A;

	logic res_accept;
	logic res_fire;
	logic s2_load;
	logic issue_fire;
	logic [`XLEN-1:0] imm_sext;
	logic [`XLEN-1:0] alu_out;

	// external write owns the bus, our result waits a cycle
	assign res_accept = res_ready && !ext_wb_valid;
	assign res_fire = res_valid && res_accept;
	assign s2_load = !res_valid || res_accept;
	assign issue.ready = !s1_valid || s2_load;
	assign issue_fire = issue.valid && issue.ready;

	assign wb_valid = ext_wb_valid || res_fire;
	assign wb_PR = ext_wb_valid ? ext_wb_PR : res_dest_PR;

	always_ff @(posedge CLK) begin
		if (ext_wb_valid)
			rf[ext_wb_PR] <= ext_wb_data;
		else if (res_fire)
			rf[res_dest_PR] <= res_data;
	end

	// ------------------------------
	// stage 1: operand read
	// ------------------------------
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST)
			s1_valid <= 1'b0;
		else if (issue.ready)
			s1_valid <= issue.valid;
	end

	always_ff @(posedge CLK) begin
		if (issue_fire) begin
			s1_op <= issue.op;
			s1_imm12 <= issue.imm12;
			s1_dest_PR <= issue.dest_PR;
			s1_ROB_index <= issue.ROB_index;
			s1_A <= (issue.A_PR == '0) ? '0 : rf[issue.A_PR];
		end
	end

	// ------------------------------
	// stage 2: ALU
	// ------------------------------
	always_comb begin
		imm_sext = {{(`XLEN - 12){s1_imm12.plain[11]}}, s1_imm12.plain};
		case (s1_op)
			ADDI: alu_out = s1_A + imm_sext;
			SLTI: alu_out = `XLEN'($signed(s1_A) < $signed(imm_sext));
			SLTIU: alu_out = `XLEN'(s1_A < imm_sext);
			XORI: alu_out = s1_A ^ imm_sext;
			ORI: alu_out = s1_A | imm_sext;
			ANDI: alu_out = s1_A & imm_sext;
			SLLI: alu_out = s1_A << s1_imm12.shift.shamt;
			// right shifts pick arithmetic from funct7
			SRLI, SRAI: begin
				if (s1_imm12.shift.upper == SRA_UPPER)
					alu_out = `XLEN'($signed(s1_A) >>> s1_imm12.shift.shamt);
				else
					alu_out = s1_A >> s1_imm12.shift.shamt;
			end
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST)
			res_valid <= 1'b0;
		else if (s2_load)
			res_valid <= s1_valid;
	end

	always_ff @(posedge CLK) begin
		if (s2_load && s1_valid) begin
			res_data <= alu_out;
			res_dest_PR <= s1_dest_PR;
			res_ROB_index <= s1_ROB_index;
		end
	end

	// operand read never races a producer still inside the pipe
	a_no_raw: assert property (@(posedge CLK) disable iff (!nRST)
		issue_fire && issue.A_PR != '0 |->
			!(s1_valid && s1_dest_PR == issue.A_PR)
			&& !(res_valid && res_dest_PR == issue.A_PR));

endmodule

`default_nettype wire

// File: verilog/alu_imm_top.sv
// ----------------------------
// alu_imm issue subsystem
// dispatch, issue queue and ALU pipe on plain ports
// ----------------------------

`default_nettype none

`include "alu_imm_cfg.svh"

module alu_imm_top import alu_imm_pkg::*; (
	input wire logic CLK,
	input wire logic nRST,

	// enqueue from rename
	input wire logic enq_valid,
	output logic enq_ready,
	input wire alu_imm_op_t enq_op,
	input wire imm12_t enq_imm12,
	input wire logic [`LOG_PR_COUNT-1:0] enq_A_PR,
	input wire logic [`LOG_PR_COUNT-1:0] enq_dest_PR,
	input wire logic [`LOG_ROB_ENTRIES-1:0] enq_ROB_index,

	// writebacks from other units
	input wire logic ext_wb_valid,
	input wire logic [`LOG_PR_COUNT-1:0] ext_wb_PR,
	input wire logic [`XLEN-1:0] ext_wb_data,

	// result
	output logic res_valid,
	input wire logic res_ready,
	output logic [`LOG_PR_COUNT-1:0] res_dest_PR,
	output logic [`LOG_ROB_ENTRIES-1:0] res_ROB_index,
	output logic [`XLEN-1:0] res_data
);

	alu_imm_if enq_if ();
	alu_imm_if issue_if ();

	// shared writeback broadcast
	logic wb_valid;
	logic [`LOG_PR_COUNT-1:0] wb_PR;

	alu_imm_dispatch u_dispatch (
		.CLK(CLK),
		.nRST(nRST),
		.enq_valid(enq_valid),
		.enq_op(enq_op),
		.enq_imm12(enq_imm12),
		.enq_A_PR(enq_A_PR),
		.enq_dest_PR(enq_dest_PR),
		.enq_ROB_index(enq_ROB_index),
		.enq_ready(enq_ready),
		.wb_valid(wb_valid),
		.wb_PR(wb_PR),
		.iq(enq_if.src)
	);

	alu_imm_iq u_iq (
		.CLK(CLK),
		.nRST(nRST),
		.enq(enq_if.dst),
		.issue(issue_if.src),
		.wb_valid(wb_valid),
		.wb_PR(wb_PR)
	);

	alu_imm_pipe u_pipe (
		.CLK(CLK),
		.nRST(nRST),
		.issue(issue_if.dst),
		.ext_wb_valid(ext_wb_valid),
		.ext_wb_PR(ext_wb_PR),
		.ext_wb_data(ext_wb_data),
		.res_ready(res_ready),
		.res_valid(res_valid),
		.res_dest_PR(res_dest_PR),
		.res_ROB_index(res_ROB_index),
		.res_data(res_data),
		.wb_valid(wb_valid),
		.wb_PR(wb_PR)
	);

endmodule

`default_nettype wire

// File: bench/alu_imm_checker.sv
// ----------------------------
// alu_imm result checker
// register model, expected results by ROB index, error counts
// ----------------------------

`default_nettype none

`include "alu_imm_cfg.svh"

module alu_imm_checker import alu_imm_pkg::*; (
	input wire logic CLK,
	input wire logic nRST,
	input wire logic enq_valid,
	input wire logic enq_ready,
	input wire alu_imm_op_t enq_op,
	input wire imm12_t enq_imm12,
	input wire logic [`LOG_PR_COUNT-1:0] enq_A_PR,
	input wire logic [`LOG_PR_COUNT-1:0] enq_dest_PR,
	input wire logic [`LOG_ROB_ENTRIES-1:0] enq_ROB_index,
	input wire logic ext_wb_valid,
	input wire logic [`LOG_PR_COUNT-1:0] ext_wb_PR,
	input wire logic [`XLEN-1:0] ext_wb_data,
	input wire logic res_valid,
	input wire logic res_ready,
	input wire logic [`LOG_PR_COUNT-1:0] res_dest_PR,
	input wire logic [`LOG_ROB_ENTRIES-1:0] res_ROB_index,
	input wire logic [`XLEN-1:0] res_data
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [`XLEN-1:0] model [`PR_COUNT];
	logic [`XLEN-1:0] exp_data [`ROB_ENTRIES];
	logic [`LOG_PR_COUNT-1:0] exp_dest [`ROB_ENTRIES];
	logic [`ROB_ENTRIES-1:0] waiting = '0;
	int pending = 0;
	int n_results = 0;
	int mismatches = 0;
	int other_errs = 0;
	logic saw_stall = 1'b0;
	// highest ROB index returned so far
	int newest_rob = -1;
	logic saw_overtake = 1'b0;

	// RISC-V immediate op rules on a 32-bit operand
	function automatic logic [`XLEN-1:0] expect_result(input alu_imm_op_t op,
			input imm12_t imm, input logic [`XLEN-1:0] a);
		logic [`XLEN-1:0] ext;
		logic [4:0] sh;
		logic [`XLEN-1:0] r;
		ext = {{20{imm[11]}}, imm};
		sh = imm.shift.shamt;
		case (op)
			ADDI: r = a + ext;
			SLTI: r = ($signed(a) < $signed(ext)) ? 32'd1 : 32'd0;
			SLTIU: r = (a < ext) ? 32'd1 : 32'd0;
			XORI: r = a ^ ext;
			ORI: r = a | ext;
			ANDI: r = a & ext;
			SLLI: r = a << sh;
			SRLI, SRAI: begin
				r = a >> sh;
				// funct7 0100000 fills with the sign bit
				if (imm.shift.upper == 7'b0100000 && a[31])
					r = r | ~(32'hffff_ffff >> sh);
			end
			default: r = 'x;
		endcase
		return r;
	endfunction

	// ------------------------------
	// monitor, sampled mid-cycle
	// ------------------------------
	always @(negedge CLK) begin
		logic [`XLEN-1:0] a_val;
		if (!nRST) begin
			if (res_valid || enq_ready) begin
				other_errs++;
				$display("%0t: res_valid or enq_ready high during reset", $time);
			end
		end else begin
			if (ext_wb_valid && ext_wb_PR != '0)
				model[ext_wb_PR] = ext_wb_data;
			if (enq_valid && !enq_ready)
				saw_stall = 1'b1;
			if (enq_valid && enq_ready) begin
				a_val = (enq_A_PR == '0) ? '0 : model[enq_A_PR];
				if (waiting[enq_ROB_index]) begin
					other_errs++;
					$display("%0t: ROB %0d enqueued again before its result came back",
						$time, enq_ROB_index);
				end
				exp_data[enq_ROB_index] = expect_result(enq_op, enq_imm12, a_val);
				exp_dest[enq_ROB_index] = enq_dest_PR;
				waiting[enq_ROB_index] = 1'b1;
				pending++;
				if (enq_dest_PR != '0)
					model[enq_dest_PR] = exp_data[enq_ROB_index];
			end
			// the pipe yields to an external write in the same cycle
			if (res_valid && res_ready && !ext_wb_valid) begin
				n_results++;
				if (!waiting[res_ROB_index]) begin
					other_errs++;
					$display("%0t: result for ROB %0d arrived with nothing outstanding",
						$time, res_ROB_index);
				end else begin
					waiting[res_ROB_index] = 1'b0;
					pending--;
					// ROB indices are handed out in order
					if (int'(res_ROB_index) < newest_rob)
						saw_overtake = 1'b1;
					else
						newest_rob = int'(res_ROB_index);
					if (res_data !== exp_data[res_ROB_index]) begin
						mismatches++;
						$display("Mismatch at %0t: res_data (ROB %0d) expected %h, actual %h",
							$time, res_ROB_index, exp_data[res_ROB_index], res_data);
					end
					if (res_dest_PR !== exp_dest[res_ROB_index]) begin
						mismatches++;
						$display("Mismatch at %0t: res_dest_PR (ROB %0d) expected %0d, actual %0d",
							$time, res_ROB_index, exp_dest[res_ROB_index], res_dest_PR);
					end
				end
			end
		end
	end

	task report();
		if (!saw_stall) begin
			other_errs++;
			$display("enq_ready never fell while results were held back");
		end
		if (!saw_overtake) begin
			other_errs++;
			$display("no result ever came back ahead of an older op");
		end
		for (int i = 0; i < `ROB_ENTRIES; i++) begin
			if (waiting[i]) begin
				other_errs++;
				$display("no result arrived for ROB %0d", i);
			end
		end
		$display("checker: %0d results, %0d mismatches, %0d other errors",
			n_results, mismatches, other_errs);
	endtask

	function automatic int error_count();
		return mismatches + other_errs;
	endfunction

endmodule

`default_nettype wire

// File: bench/alu_imm_tb.sv
// ----------------------------
// alu_imm testbench
// table of writebacks and ops under random result back-pressure
// ----------------------------

`default_nettype none

`include "alu_imm_cfg.svh"

module alu_imm_tb import alu_imm_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int K_WRITE = 0;
	localparam int K_OP = 1;
	localparam int K_DRAIN = 2;

	// one table row; duty is the res_ready percentage while the row runs
	typedef struct packed {
		int kind;
		alu_imm_op_t op;
		logic [11:0] imm;
		logic [`LOG_PR_COUNT-1:0] a_pr;
		logic [`LOG_PR_COUNT-1:0] pr;
		logic [`LOG_ROB_ENTRIES-1:0] rob;
		logic [`XLEN-1:0] data;
		int duty;
	} row_t;

	logic CLK;
	logic nRST;
	logic enq_valid;
	logic enq_ready;
	alu_imm_op_t enq_op;
	imm12_t enq_imm12;
	logic [`LOG_PR_COUNT-1:0] enq_A_PR;
	logic [`LOG_PR_COUNT-1:0] enq_dest_PR;
	logic [`LOG_ROB_ENTRIES-1:0] enq_ROB_index;
	logic ext_wb_valid;
	logic [`LOG_PR_COUNT-1:0] ext_wb_PR;
	logic [`XLEN-1:0] ext_wb_data;
	logic res_valid;
	logic res_ready;
	logic [`LOG_PR_COUNT-1:0] res_dest_PR;
	logic [`LOG_ROB_ENTRIES-1:0] res_ROB_index;
	logic [`XLEN-1:0] res_data;

	row_t rows [$];
	int n_rows = 0;
	int duty = 0;

	alu_imm_top uut (.*);
	alu_imm_checker chk (.*);

	function automatic row_t ext_write_row(input logic [`LOG_PR_COUNT-1:0] pr,
			input logic [`XLEN-1:0] data, input int d);
		row_t r;
		r = '0;
		r.kind = K_WRITE;
		r.pr = pr;
		r.data = data;
		r.duty = d;
		return r;
	endfunction

	function automatic row_t enqueue_row(input alu_imm_op_t op, input logic [11:0] imm,
			input logic [`LOG_PR_COUNT-1:0] a, input logic [`LOG_PR_COUNT-1:0] pr,
			input logic [`LOG_ROB_ENTRIES-1:0] rob, input int d);
		row_t r;
		r = '0;
		r.kind = K_OP;
		r.op = op;
		r.imm = imm;
		r.a_pr = a;
		r.pr = pr;
		r.rob = rob;
		r.duty = d;
		return r;
	endfunction

	function automatic row_t drain_row(input int d);
		row_t r;
		r = '0;
		r.kind = K_DRAIN;
		r.duty = d;
		return r;
	endfunction

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// result back-pressure
	initial begin
		int seed_val;
		seed_val = $urandom(32'h9cf38ec2);
		res_ready = 1'b0;
		forever begin
			@(posedge CLK);
			res_ready <= ($urandom % 100) < duty;
		end
	end

	initial begin
		wait (n_rows != 0);
		repeat (n_rows * 40) @(posedge CLK);
		$display("timeout after %0d cycles with %0d results outstanding",
			n_rows * 40, chk.pending);
		chk.report();
		$display("Some tests failed");
		$finish;
	end

	initial begin
		row_t r;
		nRST = 1'b0;
		enq_valid = 1'b0;
		enq_op = ADDI;
		enq_imm12 = '0;
		enq_A_PR = '0;
		enq_dest_PR = '0;
		enq_ROB_index = '0;
		ext_wb_valid = 1'b0;
		ext_wb_PR = '0;
		ext_wb_data = '0;

		// ------------------------------
		// stimulus table
		// ------------------------------
		rows.push_back(ext_write_row(1, 32'h0000_1234, 100));
		rows.push_back(ext_write_row(2, 32'hffff_f000, 100));
		rows.push_back(ext_write_row(3, 32'h8000_0011, 100));
		// x0 ignores writes
		rows.push_back(ext_write_row(0, 32'hdead_beef, 100));
		rows.push_back(enqueue_row(ADDI, 12'h7ff, 1, 20, 0, 100));
		rows.push_back(enqueue_row(ADDI, 12'h800, 2, 21, 1, 100));
		rows.push_back(enqueue_row(SLTI, 12'hfff, 2, 22, 2, 100));
		rows.push_back(enqueue_row(SLTI, 12'h005, 1, 23, 3, 100));
		rows.push_back(enqueue_row(SLTIU, 12'hfff, 1, 24, 4, 100));
		rows.push_back(enqueue_row(SLTIU, 12'h010, 3, 25, 5, 100));
		rows.push_back(enqueue_row(XORI, 12'hf0f, 1, 26, 6, 100));
		rows.push_back(enqueue_row(ORI, 12'h055, 2, 27, 7, 100));
		rows.push_back(enqueue_row(ANDI, 12'h8ff, 3, 28, 8, 100));
		rows.push_back(enqueue_row(ANDI, 12'h0f0, 1, 29, 9, 100));
		// shifts, last one picks arithmetic by funct7 alone
		rows.push_back(enqueue_row(SLLI, {7'b0, 5'd4}, 3, 30, 10, 100));
		rows.push_back(enqueue_row(SRLI, {7'b0, 5'd8}, 3, 31, 11, 100));
		rows.push_back(enqueue_row(SRAI, {7'b0100000, 5'd8}, 3, 32, 12, 100));
		rows.push_back(enqueue_row(SRLI, {7'b0100000, 5'd31}, 2, 33, 13, 100));
		rows.push_back(enqueue_row(ADDI, 12'h123, 0, 34, 14, 70));
		// dependent chain
		rows.push_back(enqueue_row(ADDI, 12'h001, 20, 35, 15, 60));
		rows.push_back(enqueue_row(SLLI, {7'b0, 5'd1}, 35, 36, 16, 60));
		rows.push_back(enqueue_row(XORI, 12'hfff, 36, 37, 17, 60));
		// young ready op passes an old waiting one
		rows.push_back(enqueue_row(ADDI, 12'h005, 37, 38, 18, 100));
		rows.push_back(enqueue_row(ORI, 12'h001, 1, 39, 19, 100));
		rows.push_back(drain_row(100));
		// seven ops fill dispatch, queue and pipe with res_ready held low
		rows.push_back(enqueue_row(ADDI, 12'h003, 1, 40, 20, 0));
		rows.push_back(enqueue_row(SLTI, 12'h000, 3, 41, 21, 0));
		rows.push_back(enqueue_row(XORI, 12'h0aa, 2, 42, 22, 0));
		rows.push_back(enqueue_row(ORI, 12'h700, 3, 43, 23, 0));
		rows.push_back(enqueue_row(ANDI, 12'hf00, 2, 44, 24, 0));
		rows.push_back(enqueue_row(SLLI, {7'b0, 5'd31}, 1, 45, 25, 0));
		rows.push_back(enqueue_row(SRAI, {7'b0100000, 5'd1}, 2, 46, 26, 0));
		rows.push_back(enqueue_row(ADDI, 12'hffe, 46, 47, 27, 50));
		rows.push_back(ext_write_row(4, 32'h0000_00f7, 50));
		rows.push_back(enqueue_row(SRAI, {7'b0100000, 5'd3}, 4, 48, 28, 50));
		n_rows = rows.size();

		repeat (2) @(posedge CLK);
		nRST <= 1'b1;

		foreach (rows[i]) begin
			r = rows[i];
			enq_valid <= 1'b0;
			ext_wb_valid <= 1'b0;
			duty <= r.duty;
			case (r.kind)
				K_WRITE: begin
					ext_wb_valid <= 1'b1;
					ext_wb_PR <= r.pr;
					ext_wb_data <= r.data;
					@(posedge CLK);
				end
				K_OP: begin
					enq_valid <= 1'b1;
					enq_op <= r.op;
					enq_imm12 <= r.imm;
					enq_A_PR <= r.a_pr;
					enq_dest_PR <= r.pr;
					enq_ROB_index <= r.rob;
					@(negedge CLK);
					while (!enq_ready)
						@(negedge CLK);
					@(posedge CLK);
				end
				default: begin
					while (chk.pending != 0)
						@(posedge CLK);
				end
			endcase
		end

		enq_valid <= 1'b0;
		ext_wb_valid <= 1'b0;
		duty <= 100;
		while (chk.pending != 0)
			@(posedge CLK);
		// room for a late duplicate to show up
		repeat (8) @(posedge CLK);
		chk.report();
		if (chk.error_count() == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/alu_imm_pkg.sv
verilog/alu_imm_if.sv
verilog/alu_imm_dispatch.sv
verilog/alu_imm_iq.sv
verilog/alu_imm_pipe.sv
verilog/alu_imm_top.sv
bench/alu_imm_checker.sv
bench/alu_imm_tb.sv
